// ==== uart_agent_consts.svh ====
`ifndef UART_AGENT_CONSTS_SVH
`define UART_AGENT_CONSTS_SVH

// widest character on the line
`define UART_CHAR_W 8

// width of every event counter
`define UART_COUNT_W 16

// width of the start-bit watchdog limit
`define UART_TIMEOUT_W 16

// data bits per character are the selector plus this
`define UART_MIN_DATA_BITS 5

`endif

// ==== uart_agent_pkg.sv ====
`include "uart_agent_consts.svh"

package uart_agent_pkg;

	// character, bits above the selected width are zero on receive
	typedef logic [`UART_CHAR_W-1:0] uart_char_t;

	// event counter value
	typedef logic [`UART_COUNT_W-1:0] uart_count_t;

	// 0 to 3 selects 5 to 8 data bits
	typedef logic [1:0] data_bits_sel_t;

	// watchdog limit in clock cycles
	typedef logic [`UART_TIMEOUT_W-1:0] uart_timeout_t;

	// transmit sequencer, each state is the bit currently on sin
	typedef enum logic [2:0] {
		tx_st_idle,
		tx_st_start,
		tx_st_data,
		tx_st_parity,
		tx_st_stop1,
		tx_st_stop2
	} tx_state_t;

	// receive sequencer, each state is the bit sampled next
	typedef enum logic [2:0] {
		rx_st_idle,
		rx_st_data,
		rx_st_parity,
		rx_st_stop1,
		rx_st_stop2,
		rx_st_report
	} rx_state_t;

endpackage

// ==== uart_frame_tx.sv ====
`timescale 1ns/1ps
`include "uart_agent_consts.svh"

module uart_frame_tx (
	input  logic                           test_rx_clk,
	input  logic                           reset,
	input  logic                           tx_start,
	input  uart_agent_pkg::uart_char_t     tx_char,
	input  logic                           stop_err_inject,
	input  uart_agent_pkg::data_bits_sel_t data_bits_sel,
	input  logic                           parity_en,
	input  logic                           even_parity,
	input  logic                           two_stop,
	output logic                           sin,
	output logic                           tx_busy,
	output logic                           tx_done
);
	import uart_agent_pkg::*;

	localparam int IDX_W = $clog2(`UART_CHAR_W);

	tx_state_t        state_q;
	logic [IDX_W-1:0] bit_idx_q;
	logic [IDX_W-1:0] last_idx;
	uart_char_t       shift_q;
	logic             par_q;
	logic             inject_q;
	logic             accept;
	logic             shift_en;

	// strobes arriving mid-frame are dropped
	assign accept = tx_start && (state_q == tx_st_idle);
	assign tx_busy = (state_q != tx_st_idle);

	// index of the last data bit, N - 1
	assign last_idx = IDX_W'(data_bits_sel) + IDX_W'(`UART_MIN_DATA_BITS - 1);

	// a data bit leaves the shifter at the end of start and of every data bit but the last
	assign shift_en = (state_q == tx_st_start)
		|| ((state_q == tx_st_data) && (bit_idx_q != last_idx));

	////////////////////////////////////////////////////////////////////////////
	// frame sequencer

	always_ff @(posedge test_rx_clk)
	begin
		if (reset)
		begin
			state_q <= tx_st_idle;
			bit_idx_q <= '0;
			sin <= 1'b1;
			tx_done <= 1'b0;
		end
		else
		begin
			tx_done <= 1'b0;
			case (state_q)
				tx_st_idle:
				begin
					sin <= 1'b1;
					if (accept)
					begin
						sin <= 1'b0;
						state_q <= tx_st_start;
					end
				end
				tx_st_start:
				begin
					sin <= shift_q[0];
					bit_idx_q <= '0;
					state_q <= tx_st_data;
				end
				tx_st_data:
				begin
					if (bit_idx_q == last_idx)
					begin
						if (parity_en)
						begin
							// par_q already holds the xor of all data bits
							sin <= even_parity ? par_q : ~par_q;
							state_q <= tx_st_parity;
						end
						else
						begin
							sin <= ~inject_q;
							state_q <= tx_st_stop1;
						end
					end
					else
					begin
						sin <= shift_q[0];
						bit_idx_q <= bit_idx_q + 1'b1;
					end
				end
				tx_st_parity:
				begin
					sin <= ~inject_q;
					state_q <= tx_st_stop1;
				end
				tx_st_stop1:
				begin
					sin <= 1'b1;
					if (two_stop)
						state_q <= tx_st_stop2;
					else
					begin
						state_q <= tx_st_idle;
						tx_done <= 1'b1;
					end
				end
				tx_st_stop2:
				begin
					sin <= 1'b1;
					state_q <= tx_st_idle;
					tx_done <= 1'b1;
				end
				default:
				begin
					sin <= 1'b1;
					state_q <= tx_st_idle;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// character shifter and running parity

	always_ff @(posedge test_rx_clk)
	begin
		if (accept)
		begin
			shift_q <= tx_char;
			inject_q <= stop_err_inject;
			par_q <= 1'b0;
		end
		else if (shift_en)
		begin
			shift_q <= shift_q >> 1;
			par_q <= par_q ^ shift_q[0];
		end
	end

endmodule

// ==== uart_frame_rx.sv ====
`timescale 1ns/1ps
`include "uart_agent_consts.svh"

module uart_frame_rx (
	input  logic                           test_rx_clk,
	input  logic                           reset,
	input  logic                           sout,
	input  logic                           rx_arm,
	input  uart_agent_pkg::uart_timeout_t  timeout_limit,
	input  uart_agent_pkg::data_bits_sel_t data_bits_sel,
	input  logic                           parity_en,
	input  logic                           even_parity,
	input  logic                           two_stop,
	output uart_agent_pkg::uart_char_t     rx_data,
	output logic                           rx_valid,
	output logic                           parity_err,
	output logic                           stop1_err,
	output logic                           stop2_err,
	output logic                           rx_timeout
);
	import uart_agent_pkg::*;

	localparam int IDX_W = $clog2(`UART_CHAR_W);

	rx_state_t        state_q;
	logic [IDX_W-1:0] bit_idx_q;
	logic [IDX_W-1:0] last_idx;
	uart_char_t       data_q;
	logic             par_q;
	logic             par_err_q;
	logic             stop1_err_q;
	logic             stop2_err_q;
	logic             start_seen;
	logic             wd_armed_q;
	uart_timeout_t    wd_count_q;

	assign last_idx = IDX_W'(data_bits_sel) + IDX_W'(`UART_MIN_DATA_BITS - 1);

	// low level on an idle line is taken as the start bit
	assign start_seen = (state_q == rx_st_idle) && !sout;

	////////////////////////////////////////////////////////////////////////////
	// frame sequencer and reported flags

	always_ff @(posedge test_rx_clk)
	begin
		if (reset)
		begin
			state_q <= rx_st_idle;
			bit_idx_q <= '0;
			rx_valid <= 1'b0;
			parity_err <= 1'b0;
			stop1_err <= 1'b0;
			stop2_err <= 1'b0;
		end
		else
		begin
			rx_valid <= 1'b0;
			case (state_q)
				rx_st_idle:
				begin
					if (!sout)
					begin
						bit_idx_q <= '0;
						state_q <= rx_st_data;
					end
				end
				rx_st_data:
				begin
					if (bit_idx_q == last_idx)
						state_q <= parity_en ? rx_st_parity : rx_st_stop1;
					else
						bit_idx_q <= bit_idx_q + 1'b1;
				end
				rx_st_parity:
					state_q <= rx_st_stop1;
				rx_st_stop1:
					state_q <= two_stop ? rx_st_stop2 : rx_st_report;
				rx_st_stop2:
					state_q <= rx_st_report;
				rx_st_report:
				begin
					// flags hold until the next report
					rx_valid <= 1'b1;
					parity_err <= par_err_q;
					stop1_err <= stop1_err_q;
					stop2_err <= stop2_err_q;
					state_q <= rx_st_idle;
				end
				default:
					state_q <= rx_st_idle;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// data capture and per-frame checks

	always_ff @(posedge test_rx_clk)
	begin
		case (state_q)
			rx_st_idle:
			begin
				if (!sout)
				begin
					data_q <= '0;
					par_q <= 1'b0;
					par_err_q <= 1'b0;
					stop1_err_q <= 1'b0;
					stop2_err_q <= 1'b0;
				end
			end
			rx_st_data:
			begin
				data_q[bit_idx_q] <= sout;
				par_q <= par_q ^ sout;
			end
			// ones over data and parity must be even when even_parity is set
			rx_st_parity:
				par_err_q <= ((par_q ^ sout) == even_parity);
			rx_st_stop1:
				stop1_err_q <= !sout;
			rx_st_stop2:
				stop2_err_q <= !sout;
			rx_st_report:
				rx_data <= data_q;
			default:
				data_q <= '0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// start-bit watchdog

	// count only advances while the receiver sits idle
	always_ff @(posedge test_rx_clk)
	begin
		if (reset)
		begin
			wd_armed_q <= 1'b0;
			wd_count_q <= '0;
			rx_timeout <= 1'b0;
		end
		else
		begin
			rx_timeout <= 1'b0;
			if (rx_arm)
			begin
				wd_armed_q <= 1'b1;
				wd_count_q <= '0;
			end
			else if (wd_armed_q)
			begin
				if (start_seen)
					wd_armed_q <= 1'b0;
				else if (state_q == rx_st_idle)
				begin
					if (wd_count_q == timeout_limit)
					begin
						rx_timeout <= 1'b1;
						wd_armed_q <= 1'b0;
					end
					else
						wd_count_q <= wd_count_q + 1'b1;
				end
			end
		end
	end

endmodule

// ==== uart_status_counters.sv ====
`timescale 1ns/1ps
`include "uart_agent_consts.svh"

module uart_status_counters (
	input  logic                        test_rx_clk,
	input  logic                        reset,
	input  logic                        count_clear,
	input  logic                        tx_done,
	input  logic                        rx_valid,
	input  logic                        parity_err,
	input  logic                        stop1_err,
	input  logic                        stop2_err,
	input  logic                        rx_timeout,
	output uart_agent_pkg::uart_count_t rx_count,
	output uart_agent_pkg::uart_count_t tx_count,
	output uart_agent_pkg::uart_count_t parity_err_count,
	output uart_agent_pkg::uart_count_t stop1_err_count,
	output uart_agent_pkg::uart_count_t stop2_err_count,
	output uart_agent_pkg::uart_count_t timeout_count,
	output uart_agent_pkg::uart_count_t err_count
);
	import uart_agent_pkg::*;

	// slot of each event in the counter array
	localparam int EVT_RX      = 0;
	localparam int EVT_TX      = 1;
	localparam int EVT_PARITY  = 2;
	localparam int EVT_STOP1   = 3;
	localparam int EVT_STOP2   = 4;
	localparam int EVT_TIMEOUT = 5;
	localparam int N_EVT       = 6;

	logic [N_EVT-1:0] evt;
	uart_count_t      count_q [N_EVT];
	uart_count_t      err_q;
	logic             err_frame;

	// error flags only mean something in the rx_valid cycle
	assign evt[EVT_RX] = rx_valid;
	assign evt[EVT_TX] = tx_done;
	assign evt[EVT_PARITY] = rx_valid && parity_err;
	assign evt[EVT_STOP1] = rx_valid && stop1_err;
	assign evt[EVT_STOP2] = rx_valid && stop2_err;
	assign evt[EVT_TIMEOUT] = rx_timeout;

	assign err_frame = rx_valid && (parity_err || stop1_err || stop2_err);

	always_ff @(posedge test_rx_clk)
	begin
		if (reset || count_clear)
		begin
			for (int i = 0; i < N_EVT; i++)
				count_q[i] <= '0;
			err_q <= '0;
		end
		else
		begin
			for (int i = 0; i < N_EVT; i++)
			begin
				if (evt[i])
					count_q[i] <= count_q[i] + 1'b1;
			end
			// a bad frame and a timeout each add one
			err_q <= err_q + uart_count_t'(err_frame) + uart_count_t'(rx_timeout);
		end
	end

	assign rx_count = count_q[EVT_RX];
	assign tx_count = count_q[EVT_TX];
	assign parity_err_count = count_q[EVT_PARITY];
	assign stop1_err_count = count_q[EVT_STOP1];
	assign stop2_err_count = count_q[EVT_STOP2];
	assign timeout_count = count_q[EVT_TIMEOUT];
	assign err_count = err_q;

endmodule

// ==== uart_line_agent.sv ====
`timescale 1ns/1ps
`include "uart_agent_consts.svh"

module uart_line_agent (
	input  logic                           test_rx_clk,
	input  logic                           reset,
	// shared frame format
	input  uart_agent_pkg::data_bits_sel_t data_bits_sel,
	input  logic                           parity_en,
	input  logic                           even_parity,
	input  logic                           two_stop,
	input  uart_agent_pkg::uart_timeout_t  timeout_limit,
	// transmit side
	input  logic                           tx_start,
	input  uart_agent_pkg::uart_char_t     tx_char,
	input  logic                           stop_err_inject,
	output logic                           sin,
	output logic                           tx_busy,
	output logic                           tx_done,
	// receive side
	input  logic                           sout,
	input  logic                           rx_arm,
	output uart_agent_pkg::uart_char_t     rx_data,
	output logic                           rx_valid,
	output logic                           parity_err,
	output logic                           stop1_err,
	output logic                           stop2_err,
	output logic                           rx_timeout,
	// counters
	input  logic                           count_clear,
	output uart_agent_pkg::uart_count_t    rx_count,
	output uart_agent_pkg::uart_count_t    tx_count,
	output uart_agent_pkg::uart_count_t    parity_err_count,
	output uart_agent_pkg::uart_count_t    stop1_err_count,
	output uart_agent_pkg::uart_count_t    stop2_err_count,
	output uart_agent_pkg::uart_count_t    timeout_count,
	output uart_agent_pkg::uart_count_t    err_count
);

	uart_frame_tx u_tx (
		.test_rx_clk     (test_rx_clk),
		.reset           (reset),
		.tx_start        (tx_start),
		.tx_char         (tx_char),
		.stop_err_inject (stop_err_inject),
		.data_bits_sel   (data_bits_sel),
		.parity_en       (parity_en),
		.even_parity     (even_parity),
		.two_stop        (two_stop),
		.sin             (sin),
		.tx_busy         (tx_busy),
		.tx_done         (tx_done)
	);

	uart_frame_rx u_rx (
		.test_rx_clk   (test_rx_clk),
		.reset         (reset),
		.sout          (sout),
		.rx_arm        (rx_arm),
		.timeout_limit (timeout_limit),
		.data_bits_sel (data_bits_sel),
		.parity_en     (parity_en),
		.even_parity   (even_parity),
		.two_stop      (two_stop),
		.rx_data       (rx_data),
		.rx_valid      (rx_valid),
		.parity_err    (parity_err),
		.stop1_err     (stop1_err),
		.stop2_err     (stop2_err),
		.rx_timeout    (rx_timeout)
	);

	// counts follow the pulses of both directions
	uart_status_counters u_counters (
		.test_rx_clk      (test_rx_clk),
		.reset            (reset),
		.count_clear      (count_clear),
		.tx_done          (tx_done),
		.rx_valid         (rx_valid),
		.parity_err       (parity_err),
		.stop1_err        (stop1_err),
		.stop2_err        (stop2_err),
		.rx_timeout       (rx_timeout),
		.rx_count         (rx_count),
		.tx_count         (tx_count),
		.parity_err_count (parity_err_count),
		.stop1_err_count  (stop1_err_count),
		.stop2_err_count  (stop2_err_count),
		.timeout_count    (timeout_count),
		.err_count        (err_count)
	);

endmodule

// ==== uart_line_agent_sva.sv ====
`timescale 1ns/1ps

module uart_line_agent_sva (
	input logic test_rx_clk,
	input logic reset,
	input logic sin,
	input logic tx_busy,
	input logic tx_done,
	input logic rx_valid,
	input logic rx_timeout,
	input logic parity_err,
	input logic stop1_err,
	input logic stop2_err
);

	// failures seen so far, read by the testbench at the end
	int assert_fails = 0;

	// line rests at mark between frames
	sin_idle_high: assert property (@(posedge test_rx_clk) disable iff (reset)
		!tx_busy |-> sin)
	else
	begin
		assert_fails++;
		$error("sin low while the transmitter is idle");
	end

	tx_done_single: assert property (@(posedge test_rx_clk) disable iff (reset)
		tx_done |-> !tx_busy ##1 !tx_done)
	else
	begin
		assert_fails++;
		$error("tx_done longer than one cycle or seen while busy");
	end

	valid_timeout_apart: assert property (@(posedge test_rx_clk) disable iff (reset)
		!(rx_valid && rx_timeout))
	else
	begin
		assert_fails++;
		$error("rx_valid and rx_timeout high in the same cycle");
	end

	// flags change only when a frame reports
	flags_with_valid: assert property (@(posedge test_rx_clk) disable iff (reset)
		($rose(parity_err) || $rose(stop1_err) || $rose(stop2_err)) |-> rx_valid)
	else
	begin
		assert_fails++;
		$error("error flag rose without rx_valid");
	end

endmodule

bind uart_line_agent uart_line_agent_sva u_sva (
	.test_rx_clk (test_rx_clk),
	.reset       (reset),
	.sin         (sin),
	.tx_busy     (tx_busy),
	.tx_done     (tx_done),
	.rx_valid    (rx_valid),
	.rx_timeout  (rx_timeout),
	.parity_err  (parity_err),
	.stop1_err   (stop1_err),
	.stop2_err   (stop2_err)
);

// ==== tb_uart_line_agent.sv ====
`timescale 1ns/1ps
`include "uart_agent_consts.svh"

module tb_uart_line_agent;
	import uart_agent_pkg::*;

	localparam int MAX_REC = 64;
	localparam int RESET_CYCLES = 10;
	localparam int GAP_CYCLES = 4;
	localparam int LONGEST_FRAME = 12;
	localparam int GAP_ALLOW = 8;

	logic           test_rx_clk;
	logic           reset;
	data_bits_sel_t data_bits_sel;
	logic           parity_en;
	logic           even_parity;
	logic           two_stop;
	uart_timeout_t  timeout_limit;
	logic           tx_start;
	uart_char_t     tx_char;
	logic           stop_err_inject;
	logic           sin;
	logic           tx_busy;
	logic           tx_done;
	logic           sout;
	logic           rx_arm;
	uart_char_t     rx_data;
	logic           rx_valid;
	logic           parity_err;
	logic           stop1_err;
	logic           stop2_err;
	logic           rx_timeout;
	logic           count_clear;
	uart_count_t    rx_count;
	uart_count_t    tx_count;
	uart_count_t    parity_err_count;
	uart_count_t    stop1_err_count;
	uart_count_t    stop2_err_count;
	uart_count_t    timeout_count;
	uart_count_t    err_count;

	// sout comes from the testbench bit stream or the looped back sin
	logic use_tb_line;
	logic tb_line;

	// one entry per pattern record
	byte rec_kind [MAX_REC];
	int  rec_sel [MAX_REC];
	int  rec_par_en [MAX_REC];
	int  rec_even [MAX_REC];
	int  rec_two [MAX_REC];
	int  rec_tmo [MAX_REC];
	int  rec_inj [MAX_REC];
	int  rec_char [MAX_REC];
	int  rec_frame [MAX_REC];
	int  rec_data [MAX_REC];
	int  rec_perr [MAX_REC];
	int  rec_s1 [MAX_REC];
	int  rec_s2 [MAX_REC];
	int  n_rec = 0;

	int cycles = 0;
	int cycle_limit = 0;
	int check_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int rx_seen = 0;
	int tx_seen = 0;
	int to_seen = 0;

	// expected counter values tallied from the records
	int exp_rx = 0;
	int exp_tx = 0;
	int exp_par = 0;
	int exp_s1 = 0;
	int exp_s2 = 0;
	int exp_to = 0;
	int exp_err = 0;

	uart_line_agent DUT (.*);

	assign sout = use_tb_line ? tb_line : sin;

	always #2 test_rx_clk = ~test_rx_clk;

	// pulses seen on the outputs
	always @(negedge test_rx_clk)
	begin
		if (!reset)
		begin
			if (rx_valid)
				rx_seen++;
			if (tx_done)
				tx_seen++;
			if (rx_timeout)
				to_seen++;
		end
	end

	always @(posedge test_rx_clk)
	begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit)
		begin
			$display("run timed out after %0d cycles with records still pending", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checking helpers

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("FAIL %0t %s expected %0h actual %0h", $time, name, expected, actual);
			check_errors++;
		end
	endtask

	task automatic finish_test(input string label, input int errs_before);
		if (check_errors == errs_before)
		begin
			tests_passed++;
			$display("test %s: ok", label);
		end
		else
		begin
			tests_failed++;
			$display("test %s: mismatch", label);
		end
	endtask

	task automatic check_counts(input int e_rx, input int e_tx, input int e_par,
		input int e_s1, input int e_s2, input int e_to, input int e_err);
		compare_value("rx_count", e_rx, rx_count);
		compare_value("tx_count", e_tx, tx_count);
		compare_value("parity_err_count", e_par, parity_err_count);
		compare_value("stop1_err_count", e_s1, stop1_err_count);
		compare_value("stop2_err_count", e_s2, stop2_err_count);
		compare_value("timeout_count", e_to, timeout_count);
		compare_value("err_count", e_err, err_count);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// pattern file

	task automatic load_patterns();
		int  fd;
		int  code;
		int  c;
		byte kind;
		fd = $fopen("uart_patterns.txt", "r");
		if (fd == 0)
		begin
			$display("could not open uart_patterns.txt");
			return;
		end
		while (!$feof(fd) && n_rec < MAX_REC)
		begin
			code = $fscanf(fd, " %c", kind);
			if (code != 1)
				break;
			if (kind == "#")
			begin
				// skip the rest of a comment line
				c = 0;
				while (c != 10 && c != -1)
					c = $fgetc(fd);
			end
			else
			begin
				rec_kind[n_rec] = kind;
				code = $fscanf(fd, "%d %d %d %d %d %d %h", rec_sel[n_rec],
					rec_par_en[n_rec], rec_even[n_rec], rec_two[n_rec], rec_tmo[n_rec],
					rec_inj[n_rec], rec_char[n_rec]);
				rec_frame[n_rec] = 0;
				if (kind == "D")
					code = $fscanf(fd, "%h", rec_frame[n_rec]);
				code = $fscanf(fd, "%h %d %d %d", rec_data[n_rec], rec_perr[n_rec],
					rec_s1[n_rec], rec_s2[n_rec]);
				if (code != 4)
				begin
					$display("pattern record %0d is incomplete", n_rec);
					check_errors++;
				end
				n_rec++;
			end
		end
		$fclose(fd);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// one record

	task automatic wait_report();
		do
			@(negedge test_rx_clk);
		while (!rx_valid && !rx_timeout);
	endtask

	task automatic run_record(input int r);
		int  errs;
		int  rx_before;
		int  tx_before;
		int  to_before;
		int  len;
		byte kind;
		kind = rec_kind[r];
		errs = check_errors;
		rx_before = rx_seen;
		tx_before = tx_seen;
		to_before = to_seen;
		// format changes only between frames
		@(posedge test_rx_clk);
		data_bits_sel <= data_bits_sel_t'(rec_sel[r]);
		parity_en <= rec_par_en[r][0];
		even_parity <= rec_even[r][0];
		two_stop <= rec_two[r][0];
		timeout_limit <= uart_timeout_t'(rec_tmo[r]);
		use_tb_line <= (kind == "D") || (kind == "T");
		tb_line <= 1'b1;
		@(posedge test_rx_clk);
		if (kind == "L" || kind == "B")
		begin
			tx_start <= 1'b1;
			tx_char <= uart_char_t'(rec_char[r]);
			stop_err_inject <= rec_inj[r][0];
			// armed with the frame so the start bit disarms it
			rx_arm <= (kind == "L");
			@(posedge test_rx_clk);
			tx_start <= 1'b0;
			rx_arm <= 1'b0;
			if (kind == "B")
			begin
				do
					@(negedge test_rx_clk);
				while (!tx_busy);
				@(posedge test_rx_clk);
				tx_start <= 1'b1;
				tx_char <= ~uart_char_t'(rec_char[r]);
				@(posedge test_rx_clk);
				tx_start <= 1'b0;
			end
		end
		else if (kind == "D")
		begin
			len = 1 + rec_sel[r] + `UART_MIN_DATA_BITS + rec_par_en[r]
				+ (rec_two[r] ? 2 : 1);
			for (int i = 0; i < len; i++)
			begin
				tb_line <= rec_frame[r][i];
				@(posedge test_rx_clk);
			end
			tb_line <= 1'b1;
		end
		else
		begin
			rx_arm <= 1'b1;
			@(posedge test_rx_clk);
			rx_arm <= 1'b0;
		end
		wait_report();
		if (kind == "T")
		begin
			compare_value("rx_timeout", 1, rx_timeout);
			compare_value("rx_valid", 0, rx_valid);
			exp_to++;
			exp_err++;
		end
		else
		begin
			compare_value("rx_timeout", 0, rx_timeout);
			compare_value("rx_data", rec_data[r], rx_data);
			compare_value("parity_err", rec_perr[r], parity_err);
			compare_value("stop1_err", rec_s1[r], stop1_err);
			compare_value("stop2_err", rec_s2[r], stop2_err);
			exp_rx++;
			exp_par += rec_perr[r];
			exp_s1 += rec_s1[r];
			exp_s2 += rec_s2[r];
			if (rec_perr[r] != 0 || rec_s1[r] != 0 || rec_s2[r] != 0)
				exp_err++;
		end
		if (kind == "L" || kind == "B")
			exp_tx++;
		repeat (GAP_CYCLES) @(negedge test_rx_clk);
		compare_value("rx_valid pulses", (kind == "T") ? 0 : 1, rx_seen - rx_before);
		compare_value("tx_done pulses", (kind == "L" || kind == "B") ? 1 : 0,
			tx_seen - tx_before);
		compare_value("rx_timeout pulses", (kind == "T") ? 1 : 0, to_seen - to_before);
		finish_test($sformatf("%0d kind %c", r, kind), errs);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// sequence

	task automatic run_all_tests();
		int widest;
		int errs;
		widest = 0;
		for (int r = 0; r < n_rec; r++)
		begin
			if (rec_tmo[r] > widest)
				widest = rec_tmo[r];
		end
		// reset and the closing checks get a fixed allowance on top
		cycle_limit = RESET_CYCLES + 16 + n_rec * (LONGEST_FRAME + widest + GAP_ALLOW);
		repeat (RESET_CYCLES) @(posedge test_rx_clk);
		reset <= 1'b0;
		@(negedge test_rx_clk);
		errs = check_errors;
		compare_value("sin", 1, sin);
		compare_value("tx_busy", 0, tx_busy);
		compare_value("rx_valid", 0, rx_valid);
		compare_value("rx_timeout", 0, rx_timeout);
		check_counts(0, 0, 0, 0, 0, 0, 0);
		finish_test("after reset", errs);
		for (int r = 0; r < n_rec; r++)
			run_record(r);
		errs = check_errors;
		repeat (2) @(negedge test_rx_clk);
		check_counts(exp_rx, exp_tx, exp_par, exp_s1, exp_s2, exp_to, exp_err);
		finish_test("counters", errs);
		errs = check_errors;
		@(posedge test_rx_clk);
		count_clear <= 1'b1;
		@(posedge test_rx_clk);
		count_clear <= 1'b0;
		@(negedge test_rx_clk);
		check_counts(0, 0, 0, 0, 0, 0, 0);
		finish_test("count clear", errs);
		errs = check_errors;
		compare_value("assertion failures", 0, DUT.u_sva.assert_fails);
		finish_test("assertions", errs);
	endtask

	initial
	begin
		test_rx_clk = 1'b0;
		reset = 1'b1;
		data_bits_sel = '0;
		parity_en = 1'b0;
		even_parity = 1'b0;
		two_stop = 1'b0;
		timeout_limit = '0;
		tx_start = 1'b0;
		tx_char = '0;
		stop_err_inject = 1'b0;
		rx_arm = 1'b0;
		count_clear = 1'b0;
		use_tb_line = 1'b1;
		tb_line = 1'b1;
		load_patterns();
		if (n_rec == 0)
		begin
			$display("no stimulus records were loaded");
			$display("*** FAILED ***");
		end
		else
		begin
			run_all_tests();
			$display("tests passed %0d failed %0d", tests_passed, tests_failed);
			if (tests_failed == 0 && check_errors == 0)
				$display("*** PASSED ***");
			else
				$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== uart_patterns.txt ====
# kind sel par_en even two_stop timeout inject char [frame, D only] exp_data perr s1err s2err
# sel 0..3 is 5..8 data bits, frame is hex with the start bit in bit 0
# loopback, every width, one and two stop bits
L 0 0 0 0 20 0 a5 05 0 0 0
L 1 0 0 0 20 0 a5 25 0 0 0
L 2 0 0 0 20 0 d6 56 0 0 0
L 3 0 0 0 20 0 3c 3c 0 0 0
L 0 0 0 1 20 0 ff 1f 0 0 0
L 1 0 0 1 20 0 c3 03 0 0 0
L 2 0 0 1 20 0 7e 7e 0 0 0
L 3 0 0 1 20 0 81 81 0 0 0
# loopback with even and odd parity
L 3 1 1 0 20 0 55 55 0 0 0
L 3 1 0 0 20 0 55 55 0 0 0
L 0 1 1 1 20 0 13 13 0 0 0
L 2 1 0 1 20 0 6a 6a 0 0 0
# stop bit error injection
L 3 0 0 0 20 1 42 42 0 1 0
L 1 1 1 1 20 1 2d 2d 0 1 0
# second strobe while busy
B 3 0 0 0 20 0 a5 a5 0 0 0
B 0 1 0 1 20 0 0e 0e 0 0 0
# direct frames, inverted parity, bad stop bits, one clean frame
D 3 1 1 0 20 0 55 6aa 55 1 0 0
D 0 1 0 1 20 0 0b 1d6 0b 1 0 0
D 2 0 0 1 20 0 3a 174 3a 0 0 1
D 1 1 1 0 20 0 2b 156 2b 0 0 0
D 3 0 0 1 20 0 c4 588 c4 0 1 0
# watchdog with the line held at mark
T 3 0 0 0 30 0 00 00 0 0 0
T 0 1 1 1 45 0 00 00 0 0 0
T 1 0 0 0 5 0 00 00 0 0 0
# longest frame after the timeouts
L 3 1 1 1 20 0 99 99 0 0 0

// ==== list.f ====
+incdir+.
uart_agent_pkg.sv
uart_frame_tx.sv
uart_frame_rx.sv
uart_status_counters.sv
uart_line_agent.sv
uart_line_agent_sva.sv
tb_uart_line_agent.sv

// ==== Bender.yml ====
package:
  name: uart_line_agent

sources:
  - include_dirs:
      - .
    files:
      - uart_agent_pkg.sv
      - uart_frame_tx.sv
      - uart_frame_rx.sv
      - uart_status_counters.sv
      - uart_line_agent.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - uart_line_agent_sva.sv
      - tb_uart_line_agent.sv
